// ==== rtl/chanlink_pkg.sv ====
package chanlink_pkg;

	//////////////////////////////////////////////////
	// Widths and word types
	//////////////////////////////////////////////////
	localparam int SAMPLE_W = 12;

	typedef logic [SAMPLE_W-1:0] sample_t;   // ADC sample
	typedef logic [15:0]         link_word_t;
	typedef logic [14:0]         crc_t;
	typedef logic [SAMPLE_W:0]   crc_data_t; // Zero plus sample
	typedef logic [6:0]          seq_t;      // Word index in frame
	typedef logic [23:0]         l1a_cnt_t;
	typedef logic [4:0]          occ_t;      // L1A buffer fill level

	localparam int EVT_FIFO_W = SAMPLE_W + 2;           // Multi-overlap, overlap, sample
	localparam int L1A_FIFO_W = $bits(l1a_cnt_t) + 1;   // Phase, trigger number
	localparam int EVT_DEPTH  = 256;
	localparam int L1A_DEPTH  = 16;

	//////////////////////////////////////////////////
	// Frame layout
	//////////////////////////////////////////////////
	localparam seq_t FRAME_DATA_WORDS = 7'd96;
	localparam seq_t FRAME_LAST_SEQ   = 7'd99;
	localparam seq_t CRC_SEQ          = 7'd96;
	localparam seq_t MARKER_SEQ       = 7'd97;
	localparam seq_t INFO_SEQ         = 7'd98;
	localparam seq_t FILL_SEQ         = 7'd99;

	localparam link_word_t MARKER_WORD = 16'h700C;
	localparam link_word_t FILL_WORD   = 16'h7FFF;
	localparam logic [3:0] INFO_TAG    = 4'h7;

	localparam seq_t PHASE_WIN_FIRST = 7'd72;   // Trigger phase on serial bit
	localparam seq_t PHASE_WIN_LAST  = 7'd77;
	localparam seq_t SAMP_WIN_FIRST  = 7'd90;   // Sixteen-sample flag on serial bit
	localparam seq_t SAMP_WIN_LAST   = 7'd95;
	localparam logic [6:0] SAMP_SIXTEEN = 7'h0F;

	typedef enum logic [2:0] {
		IDLE,
		START,
		DATA,
		TRAILER,
		DONE
	} frame_state_t;

	// One step of the 15-bit frame CRC over a 13-bit word
	function automatic crc_t crc15_d13(input crc_data_t d, input crc_t c);
		crc_t n;
		n[0]  = d[0] ^ c[2];
		n[1]  = d[0] ^ d[1] ^ c[2] ^ c[3];
		n[2]  = d[1] ^ d[2] ^ c[3] ^ c[4];
		n[3]  = d[2] ^ d[3] ^ c[4] ^ c[5];
		n[4]  = d[3] ^ d[4] ^ c[5] ^ c[6];
		n[5]  = d[4] ^ d[5] ^ c[6] ^ c[7];
		n[6]  = d[5] ^ d[6] ^ c[7] ^ c[8];
		n[7]  = d[6] ^ d[7] ^ c[8] ^ c[9];
		n[8]  = d[7] ^ d[8] ^ c[9] ^ c[10];
		n[9]  = d[8] ^ d[9] ^ c[10] ^ c[11];
		n[10] = d[9] ^ d[10] ^ c[11] ^ c[12];
		n[11] = d[10] ^ d[11] ^ c[12] ^ c[13];
		n[12] = d[11] ^ d[12] ^ c[13] ^ c[14];
		n[13] = d[12] ^ c[14] ^ c[0];
		n[14] = c[1];
		return n;
	endfunction

endpackage

// ==== rtl/sync_fifo.sv ====
module sync_fifo #(
	parameter int DATA_W = 8,
	parameter int DEPTH  = 16
) (
	input  logic                       RCLK,
	input  logic                       RST_RESYNC,
	input  logic                       push_i,
	input  logic                       pop_i,
	input  logic [DATA_W-1:0]          data_i,
	output logic [DATA_W-1:0]          data_o,
	output logic                       empty_o,
	output logic [$clog2(DEPTH+1)-1:0] level_o
);

	localparam int PTR_W = $clog2(DEPTH);

	logic [DATA_W-1:0] mem [DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic              do_push;
	logic              do_pop;

	assign empty_o = (level_o == '0);
	assign do_push = push_i && (level_o != DEPTH[$clog2(DEPTH+1)-1:0]);   // Drop when full
	assign do_pop  = pop_i && !empty_o;                                  // Drop when empty

	// Show-ahead head, zero while empty
	assign data_o = empty_o ? '0 : mem[rd_ptr];

	always_ff @(posedge RCLK) begin
		if (do_push) begin
			mem[wr_ptr] <= data_i;
		end
	end

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			level_o <= '0;
		end
		else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;   // Wraps at DEPTH
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   level_o <= level_o + 1'b1;
				2'b01:   level_o <= level_o - 1'b1;
				default: level_o <= level_o;
			endcase
		end
	end

endmodule

// ==== rtl/seq_counter.sv ====
module seq_counter (
	input  logic               RCLK,
	input  logic               RST_RESYNC,
	input  logic               clear_i,
	input  logic               step_i,
	output chanlink_pkg::seq_t seq_o,
	output logic               data_end_o,
	output logic               frame_end_o
);

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			seq_o <= '0;
		end
		else if (clear_i) begin
			seq_o <= '0;            // New frame
		end
		else if (step_i) begin
			seq_o <= seq_o + 1'b1;
		end
	end

	// Frame boundaries seen by the FSM
	assign data_end_o  = (seq_o == chanlink_pkg::FRAME_DATA_WORDS - 7'd1);
	assign frame_end_o = (seq_o == chanlink_pkg::FRAME_LAST_SEQ);

endmodule

// ==== rtl/frame_sequencer.sv ====
module frame_sequencer (
	input  logic       RCLK,
	input  logic       RST_RESYNC,
	input  logic [8:0] evt_level_i,
	input  logic       l1a_empty_i,
	input  logic       data_end_i,
	input  logic       frame_end_i,
	output logic       rd_o,
	output logic       retire_o,
	output logic       clr_crc_o,
	output logic       valid_o,
	output logic       seq_clear_o,
	output logic       seq_step_o
);

	chanlink_pkg::frame_state_t state;
	chanlink_pkg::frame_state_t state_nxt;

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			state <= chanlink_pkg::IDLE;
		end
		else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			chanlink_pkg::IDLE: begin
				// Need a trigger record and a whole frame of samples
				if (!l1a_empty_i && (evt_level_i >= chanlink_pkg::FRAME_DATA_WORDS)) begin
					state_nxt = chanlink_pkg::START;
				end
			end
			chanlink_pkg::START: state_nxt = chanlink_pkg::DATA;
			chanlink_pkg::DATA: begin
				if (data_end_i) begin
					state_nxt = chanlink_pkg::TRAILER;
				end
			end
			chanlink_pkg::TRAILER: begin
				if (frame_end_i) begin
					state_nxt = chanlink_pkg::DONE;
				end
			end
			chanlink_pkg::DONE: state_nxt = chanlink_pkg::IDLE;
			default: state_nxt = chanlink_pkg::IDLE;
		endcase
	end

	//////////////////////////////////////////////////
	// State decoded strobes
	//////////////////////////////////////////////////
	assign rd_o        = (state == chanlink_pkg::DATA);    // Pop one sample per word
	assign valid_o     = (state == chanlink_pkg::DATA) || (state == chanlink_pkg::TRAILER);
	assign clr_crc_o   = (state == chanlink_pkg::START);
	assign seq_clear_o = (state == chanlink_pkg::START);
	assign seq_step_o  = valid_o;
	assign retire_o    = (state == chanlink_pkg::DONE);    // Frees the trigger record

endmodule

// ==== rtl/frame_builder.sv ====
module frame_builder (
	input  logic                     RCLK,
	input  logic                     RST_RESYNC,
	input  chanlink_pkg::sample_t    sample_i,
	input  logic                     ovrlp_i,
	input  logic                     mlt_ovlp_i,
	input  chanlink_pkg::l1a_cnt_t   l1a_cnt_i,
	input  logic                     l1a_phase_i,
	input  chanlink_pkg::occ_t       occ_i,
	input  logic                     warn_i,
	input  logic [6:0]               samp_max_i,
	input  chanlink_pkg::seq_t       seq_i,
	input  logic                     valid_i,
	input  logic                     retire_i,
	input  logic                     clr_crc_i,
	output chanlink_pkg::link_word_t dout_o,
	output logic                     dvalid_o,
	output logic                     last_wrd_o,
	output logic                     ovlp_mux_o,
	output logic                     mlt_ovlp_o
);

	chanlink_pkg::link_word_t fullwrd;   // Stage 1
	chanlink_pkg::seq_t       seq1;
	logic                     valid1;
	logic                     ovlp_bit;
	logic                     mlt1;
	chanlink_pkg::crc_t       crc;
	chanlink_pkg::link_word_t frame;     // Stage 2
	logic                     valid2;
	logic                     ovlp_frm;
	logic                     mlt2;
	logic                     retire_r;
	logic                     serial;
	logic                     data_wrd1;

	// Serial bit windows
	always_comb begin
		if ((seq_i >= chanlink_pkg::PHASE_WIN_FIRST) && (seq_i <= chanlink_pkg::PHASE_WIN_LAST)) begin
			serial = l1a_phase_i;
		end
		else if ((seq_i >= chanlink_pkg::SAMP_WIN_FIRST) && (seq_i <= chanlink_pkg::SAMP_WIN_LAST)) begin
			serial = (samp_max_i == chanlink_pkg::SAMP_SIXTEEN);
		end
		else begin
			serial = 1'b0;
		end
	end

	assign data_wrd1 = valid1 && (seq1 < chanlink_pkg::FRAME_DATA_WORDS);

	//////////////////////////////////////////////////
	// Stage 1, link word and CRC
	//////////////////////////////////////////////////
	always_ff @(posedge RCLK) begin
		fullwrd  <= {1'b0, ~ovrlp_i, serial, 1'b0, sample_i};
		seq1     <= seq_i;
		ovlp_bit <= ovrlp_i;
	end

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			valid1 <= 1'b0;
			mlt1   <= 1'b0;
		end
		else begin
			valid1 <= valid_i;
			mlt1   <= mlt_ovlp_i;
		end
	end

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			crc <= '0;
		end
		else if (clr_crc_i) begin
			crc <= '0;   // Frame start
		end
		else if (data_wrd1) begin
			crc <= chanlink_pkg::crc15_d13({1'b0, fullwrd[chanlink_pkg::SAMPLE_W-1:0]}, crc);
		end
	end

	//////////////////////////////////////////////////
	// Stage 2, trailer insertion
	//////////////////////////////////////////////////
	always_ff @(posedge RCLK) begin
		case (seq1)
			chanlink_pkg::CRC_SEQ:    frame <= {1'b0, crc};
			chanlink_pkg::MARKER_SEQ: frame <= chanlink_pkg::MARKER_WORD;
			chanlink_pkg::INFO_SEQ:   frame <= {chanlink_pkg::INFO_TAG, l1a_cnt_i[5:0], occ_i, warn_i};
			chanlink_pkg::FILL_SEQ:   frame <= chanlink_pkg::FILL_WORD;
			default:                  frame <= fullwrd;
		endcase
	end

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			valid2   <= 1'b0;
			ovlp_frm <= 1'b0;
			mlt2     <= 1'b0;
			retire_r <= 1'b0;
		end
		else begin
			valid2   <= valid1;
			mlt2     <= mlt1;
			retire_r <= retire_i;
			if (data_wrd1) begin
				ovlp_frm <= ~ovlp_bit;   // Held through the trailer
			end
		end
	end

	//////////////////////////////////////////////////
	// Stage 3, outputs
	//////////////////////////////////////////////////
	always_ff @(posedge RCLK) begin
		dout_o <= frame;
	end

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			dvalid_o   <= 1'b0;
			ovlp_mux_o <= 1'b0;
			mlt_ovlp_o <= 1'b0;
			last_wrd_o <= 1'b0;
		end
		else begin
			dvalid_o   <= valid2;
			ovlp_mux_o <= ovlp_frm;
			mlt_ovlp_o <= mlt2;
			last_wrd_o <= retire_r;   // Lines up with fill word
		end
	end

endmodule

// ==== rtl/chanlink_readout.sv ====
module chanlink_readout (
	input  logic                     RCLK,
	input  logic                     RST_RESYNC,
	input  logic                     wren_i,
	input  chanlink_pkg::sample_t    wdata_i,
	input  logic                     ovrlp_i,
	input  logic                     mlt_ovlp_i,
	input  logic                     l1a_wrt_en_i,
	input  logic                     l1a_match_i,
	input  chanlink_pkg::l1a_cnt_t   l1a_cnt_i,
	input  logic                     l1a_phase_i,
	input  logic                     warn_i,
	input  logic [6:0]               samp_max_i,
	output chanlink_pkg::link_word_t dout_o,
	output logic                     dvalid_o,
	output logic                     last_wrd_o,
	output logic                     ovlp_mux_o,
	output logic                     mlt_ovlp_o
);

	chanlink_pkg::sample_t  evt_sample;   // Event buffer head
	logic                   evt_ovrlp;
	logic                   evt_mlt;
	logic [8:0]             evt_level;
	chanlink_pkg::l1a_cnt_t l1a_num;      // L1A buffer head
	logic                   l1a_phs;
	logic                   l1a_empty;
	chanlink_pkg::occ_t     l1a_occ;
	logic                   rd;
	logic                   retire;
	logic                   clr_crc;
	logic                   valid;
	logic                   seq_clear;
	logic                   seq_step;
	chanlink_pkg::seq_t     seq;
	logic                   data_end;
	logic                   frame_end;

	sync_fifo #(
		.DATA_W (chanlink_pkg::EVT_FIFO_W),
		.DEPTH  (chanlink_pkg::EVT_DEPTH)
	) i_evt_buf (
		.RCLK       (RCLK),
		.RST_RESYNC (RST_RESYNC),
		.push_i     (wren_i),
		.pop_i      (rd),
		.data_i     ({mlt_ovlp_i, ovrlp_i, wdata_i}),
		.data_o     ({evt_mlt, evt_ovrlp, evt_sample}),
		.empty_o    (),
		.level_o    (evt_level)
	);

	sync_fifo #(
		.DATA_W (chanlink_pkg::L1A_FIFO_W),
		.DEPTH  (chanlink_pkg::L1A_DEPTH)
	) i_l1a_buf (
		.RCLK       (RCLK),
		.RST_RESYNC (RST_RESYNC),
		.push_i     (l1a_wrt_en_i & l1a_match_i),   // Unmatched triggers dropped
		.pop_i      (retire),
		.data_i     ({l1a_phase_i, l1a_cnt_i}),
		.data_o     ({l1a_phs, l1a_num}),
		.empty_o    (l1a_empty),
		.level_o    (l1a_occ)
	);

	frame_sequencer i_frame_sequencer (
		.RCLK        (RCLK),
		.RST_RESYNC  (RST_RESYNC),
		.evt_level_i (evt_level),
		.l1a_empty_i (l1a_empty),
		.data_end_i  (data_end),
		.frame_end_i (frame_end),
		.rd_o        (rd),
		.retire_o    (retire),
		.clr_crc_o   (clr_crc),
		.valid_o     (valid),
		.seq_clear_o (seq_clear),
		.seq_step_o  (seq_step)
	);

	seq_counter i_seq_counter (
		.RCLK        (RCLK),
		.RST_RESYNC  (RST_RESYNC),
		.clear_i     (seq_clear),
		.step_i      (seq_step),
		.seq_o       (seq),
		.data_end_o  (data_end),
		.frame_end_o (frame_end)
	);

	frame_builder i_frame_builder (
		.RCLK        (RCLK),
		.RST_RESYNC  (RST_RESYNC),
		.sample_i    (evt_sample),
		.ovrlp_i     (evt_ovrlp),
		.mlt_ovlp_i  (evt_mlt),
		.l1a_cnt_i   (l1a_num),
		.l1a_phase_i (l1a_phs),
		.occ_i       (l1a_occ),
		.warn_i      (warn_i),
		.samp_max_i  (samp_max_i),
		.seq_i       (seq),
		.valid_i     (valid),
		.retire_i    (retire),
		.clr_crc_i   (clr_crc),
		.dout_o      (dout_o),
		.dvalid_o    (dvalid_o),
		.last_wrd_o  (last_wrd_o),
		.ovlp_mux_o  (ovlp_mux_o),
		.mlt_ovlp_o  (mlt_ovlp_o)
	);

endmodule

// ==== verification/chanlink_readout_tb.sv ====
module chanlink_readout_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int MAX_REC = 64;

	logic                     RCLK = 1'b0;
	logic                     RST_RESYNC;
	logic                     wren_i;
	chanlink_pkg::sample_t    wdata_i;
	logic                     ovrlp_i;
	logic                     mlt_ovlp_i;
	logic                     l1a_wrt_en_i;
	logic                     l1a_match_i;
	chanlink_pkg::l1a_cnt_t   l1a_cnt_i;
	logic                     l1a_phase_i;
	logic                     warn_i;
	logic [6:0]               samp_max_i;
	chanlink_pkg::link_word_t dout_o;
	logic                     dvalid_o;
	logic                     last_wrd_o;
	logic                     ovlp_mux_o;
	logic                     mlt_ovlp_o;

	// Records from the stimulus file
	logic [23:0] rec_cnt   [MAX_REC];
	logic        rec_phase [MAX_REC];
	logic        rec_match [MAX_REC];
	logic        rec_warn  [MAX_REC];
	logic [6:0]  rec_smax  [MAX_REC];
	logic [1:0]  rec_ovsel [MAX_REC];
	logic        rec_burst [MAX_REC];
	logic [15:0] rec_info  [MAX_REC];
	int          nrec = 0;

	// Expected output words, one entry per dvalid_o cycle
	logic [15:0] exp_word_q [$];
	logic        exp_ovl_q  [$];
	logic        exp_mlt_q  [$];
	int          exp_idx_q  [$];
	logic        frm_warn_q [$];   // Levels per frame
	logic [6:0]  frm_smax_q [$];

	int          loaded_frames = 0;
	int          done_frames   = 0;
	int          err_cnt       = 0;
	int          chk_cnt       = 0;
	int          cycle_cnt     = 0;
	int          cycle_limit   = 1000;
	int          word_pos      = 0;
	logic [31:0] lcg_state     = 32'h852a722b;
	logic [15:0] w_exp;
	logic        ovl_exp;
	logic        mlt_exp;
	int          idx_exp;

	chanlink_readout i_chanlink_readout (
		.RCLK         (RCLK),
		.RST_RESYNC   (RST_RESYNC),
		.wren_i       (wren_i),
		.wdata_i      (wdata_i),
		.ovrlp_i      (ovrlp_i),
		.mlt_ovlp_i   (mlt_ovlp_i),
		.l1a_wrt_en_i (l1a_wrt_en_i),
		.l1a_match_i  (l1a_match_i),
		.l1a_cnt_i    (l1a_cnt_i),
		.l1a_phase_i  (l1a_phase_i),
		.warn_i       (warn_i),
		.samp_max_i   (samp_max_i),
		.dout_o       (dout_o),
		.dvalid_o     (dvalid_o),
		.last_wrd_o   (last_wrd_o),
		.ovlp_mux_o   (ovlp_mux_o),
		.mlt_ovlp_o   (mlt_ovlp_o)
	);

	always #2ns RCLK = ~RCLK;   // 4 ns period

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic next_slot();
		@(posedge RCLK);
		#1ns;
	endtask

	//////////////////////////////////////////////////
	// One record, samples first, then the trigger
	//////////////////////////////////////////////////
	task automatic load_record(input int r);
		logic [11:0] s;
		logic        ov;
		logic        ml;
		logic        ser;
		logic [14:0] crc;
		logic        last_ov;
		crc     = '0;
		last_ov = 1'b0;
		if (rec_match[r]) begin
			frm_warn_q.push_back(rec_warn[r]);
			frm_smax_q.push_back(rec_smax[r]);
			loaded_frames++;
			for (int i = 0; i < 96; i++) begin
				lcg_state = lcg_next(lcg_state);
				s = lcg_state[27:16];
				case (rec_ovsel[r])
					2'd0:    ov = 1'b0;
					2'd1:    ov = 1'b1;
					2'd2:    ov = i[0];      // Alternating
					default: ov = lcg_state[9];
				endcase
				ml = lcg_state[5];
				if (i >= 72 && i <= 77) begin
					ser = rec_phase[r];       // Trigger phase window
				end
				else if (i >= 90 && i <= 95) begin
					ser = (rec_smax[r] == 7'd15);
				end
				else begin
					ser = 1'b0;
				end
				crc     = chanlink_pkg::crc15_d13({1'b0, s}, crc);
				last_ov = ~ov;
				exp_word_q.push_back({1'b0, ~ov, ser, 1'b0, s});
				exp_ovl_q.push_back(~ov);
				exp_mlt_q.push_back(ml);
				exp_idx_q.push_back(i);
				wren_i     = 1'b1;
				wdata_i    = s;
				ovrlp_i    = ov;
				mlt_ovlp_i = ml;
				next_slot();
			end
			wren_i = 1'b0;
			exp_word_q.push_back({1'b0, crc});
			exp_word_q.push_back(16'h700C);
			exp_word_q.push_back(rec_info[r]);
			exp_word_q.push_back(16'h7FFF);
			for (int i = 96; i < 100; i++) begin
				exp_ovl_q.push_back(last_ov);   // Held from word 95
				exp_mlt_q.push_back(1'b0);
				exp_idx_q.push_back(i);
			end
		end
		l1a_wrt_en_i = 1'b1;
		l1a_match_i  = rec_match[r];
		l1a_cnt_i    = rec_cnt[r];
		l1a_phase_i  = rec_phase[r];
		next_slot();
		l1a_wrt_en_i = 1'b0;
		l1a_match_i  = 1'b0;
	endtask

	// warn_i and samp_max_i follow the frame being read out
	initial begin
		warn_i     = 1'b0;
		samp_max_i = '0;
		forever begin
			next_slot();
			if (done_frames < loaded_frames) begin
				warn_i     = frm_warn_q[done_frames];
				samp_max_i = frm_smax_q[done_frames];
			end
		end
	end

	//////////////////////////////////////////////////
	// Output monitor
	//////////////////////////////////////////////////
	always @(negedge RCLK) begin
		if (!RST_RESYNC && dvalid_o) begin
			assert (exp_word_q.size() != 0) else begin
				$display("output word %h arrived with no frame pending", dout_o);
				err_cnt++;
			end
			if (exp_word_q.size() != 0) begin
				w_exp   = exp_word_q.pop_front();
				ovl_exp = exp_ovl_q.pop_front();
				mlt_exp = exp_mlt_q.pop_front();
				idx_exp = exp_idx_q.pop_front();
				chk_cnt += 3;
				assert (dout_o == w_exp) else begin
					$display("error dout_o word %0d exp %h got %h", idx_exp, w_exp, dout_o);
					err_cnt++;
				end
				assert (ovlp_mux_o == ovl_exp) else begin
					$display("error ovlp_mux_o exp %h got %h", ovl_exp, ovlp_mux_o);
					err_cnt++;
				end
				assert (last_wrd_o == (idx_exp == 99)) else begin
					$display("error last_wrd_o exp %h got %h", idx_exp == 99, last_wrd_o);
					err_cnt++;
				end
				if (idx_exp < 96) begin
					chk_cnt++;
					assert (mlt_ovlp_o == mlt_exp) else begin
						$display("error mlt_ovlp_o exp %h got %h", mlt_exp, mlt_ovlp_o);
						err_cnt++;
					end
				end
				if (idx_exp == 99) begin
					done_frames++;
				end
			end
			word_pos = (word_pos == 99) ? 0 : word_pos + 1;
		end
		else if (!RST_RESYNC) begin
			assert (word_pos == 0) else begin
				$display("dvalid_o dropped after %0d words of a frame", word_pos);
				err_cnt++;
				word_pos = 0;
			end
			assert (!last_wrd_o) else begin
				$display("last_wrd_o went high outside a frame");
				err_cnt++;
			end
		end
	end

	always @(posedge RCLK) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("timeout after %0d cycles with frames still outstanding", cycle_cnt);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////
	initial begin
		int          fd;
		int          code;
		string       line;
		logic [31:0] f [8];
		RST_RESYNC   = 1'b1;
		wren_i       = 1'b0;
		wdata_i      = '0;
		ovrlp_i      = 1'b0;
		mlt_ovlp_i   = 1'b0;
		l1a_wrt_en_i = 1'b0;
		l1a_match_i  = 1'b0;
		l1a_cnt_i    = '0;
		l1a_phase_i  = 1'b0;
		fd = $fopen("verification/chanlink_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file");
			err_cnt++;
		end
		else begin
			while (!$feof(fd)) begin
				line = "";
				code = $fgets(line, fd);
				if (line.len() > 1 && line[0] != 8'h23) begin   // Skip comment lines
					code = $sscanf(line, "%h %h %h %h %h %h %h %h",
						f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
					if (code == 8 && nrec < MAX_REC) begin
						rec_cnt[nrec]   = f[0][23:0];
						rec_phase[nrec] = f[1][0];
						rec_match[nrec] = f[2][0];
						rec_warn[nrec]  = f[3][0];
						rec_smax[nrec]  = f[4][6:0];
						rec_ovsel[nrec] = f[5][1:0];
						rec_burst[nrec] = f[6][0];
						rec_info[nrec]  = f[7][15:0];
						nrec++;
					end
				end
			end
			$fclose(fd);
		end
		cycle_limit = 130 * nrec + 500;

		repeat (16) @(posedge RCLK);
		#1ns;
		RST_RESYNC = 1'b0;
		next_slot();
		next_slot();
		chk_cnt++;
		assert (!dvalid_o && !last_wrd_o && !mlt_ovlp_o && !ovlp_mux_o) else begin
			$display("control outputs not low after reset");
			err_cnt++;
		end

		for (int r = 0; r < nrec; r++) begin
			if (!rec_burst[r]) begin
				while (done_frames != loaded_frames) begin
					next_slot();
				end
				repeat (3) next_slot();
			end
			load_record(r);
		end
		while (done_frames != loaded_frames) begin
			next_slot();
		end
		repeat (10) next_slot();   // No stray frame afterwards
		assert (exp_word_q.size() == 0) else begin
			$display("%0d expected words never came out", exp_word_q.size());
			err_cnt++;
		end

		$display("frames %0d, checks %0d, errors %0d", done_frames, chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("RESULT: PASS");
		end
		else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== verification/chanlink_stimulus.txt ====
# l1a_cnt phase match warn samp_max ovsel burst info (all hex)
# ovsel 0 none, 1 all, 2 alternating, 3 random; burst 1 loads without waiting
000001 0 1 0 0F 0 0 7042
000002 1 1 1 03 1 0 7083
000003 1 1 0 0F 2 0 70C2
0000A5 0 0 0 00 0 0 0000
000044 1 1 1 0F 3 0 7103
00013F 0 1 0 7F 3 0 7FC4
000ABC 1 1 1 0F 2 1 7F05
123456 0 1 0 0E 1 1 7582
00FFC0 1 1 1 0F 3 0 7003
000077 0 0 1 0F 1 0 0000
000010 0 1 1 10 0 0 7405
000020 1 1 0 0F 3 1 7802

// ==== all.f ====
rtl/chanlink_pkg.sv
rtl/sync_fifo.sv
rtl/seq_counter.sv
rtl/frame_sequencer.sv
rtl/frame_builder.sv
rtl/chanlink_readout.sv
verification/chanlink_readout_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := chanlink_readout_tb
FILELIST  := all.f
OBJDIR    := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal --Mdir $(OBJDIR) --top-module $(TOP)
LINTFLAGS := --lint-only --timing -Wall --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^RESULT: PASS$$'

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
